//--- exe_stage.f
logic/exe_pkg.sv
logic/exe_issue_reg.sv
logic/divider.sv
logic/alu.sv
logic/store_unit.sv
logic/exe_stage.sv
verification/exe_stage_checker.sv
verification/exe_stage_monitor.sv
verification/exe_stage_tb.sv

//--- logic/alu.sv
module alu (
    input  logic            clk,
    input  logic            resetn,
    input  logic            op_valid,
    input  logic            retire,
    input  exe_pkg::alu_op_t alu_op,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result,
    output logic            complete
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    div_state_t div_state;

    logic           is_sub;
    logic [32:0]    adder_sum;
    logic           slt_res;
    logic           sltu_res;
    logic [4:0]     shamt;
    logic [32:0]    mul_a;
    logic [32:0]    mul_b;
    logic [65:0]    product;
    logic           is_div_op;
    logic           div_signed;
    logic           div_start;
    logic           div_done;
    exe_pkg::word_t div_quo;
    exe_pkg::word_t div_rem;

    // shared adder for add, sub and the compares
    assign is_sub    = alu_op[exe_pkg::ALU_SUB] | alu_op[exe_pkg::ALU_SLT]
                     | alu_op[exe_pkg::ALU_SLTU];
    assign adder_sum = {1'b0, src1} + {1'b0, is_sub ? ~src2 : src2} + {32'd0, is_sub};
    assign slt_res   = (src1[31] & ~src2[31])
                     | (~(src1[31] ^ src2[31]) & adder_sum[31]);
    assign sltu_res  = ~adder_sum[32];
    assign shamt     = src2[4:0];

    // 33x33 signed multiply covers both mulh forms
    assign mul_a   = {alu_op[exe_pkg::ALU_MULH] & src1[31], src1};
    assign mul_b   = {alu_op[exe_pkg::ALU_MULH] & src2[31], src2};
    assign product = $signed(mul_a) * $signed(mul_b);

    assign is_div_op  = alu_op[exe_pkg::ALU_DIV] | alu_op[exe_pkg::ALU_MOD]
                      | alu_op[exe_pkg::ALU_DIVU] | alu_op[exe_pkg::ALU_MODU];
    assign div_signed = alu_op[exe_pkg::ALU_DIV] | alu_op[exe_pkg::ALU_MOD];

    // one start per instruction in its first cycle
    assign div_start = op_valid & is_div_op & (div_state == DIV_IDLE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_state <= DIV_IDLE;
        end else begin
            case (div_state)
                DIV_IDLE: if (div_start) div_state <= DIV_RUN;
                DIV_RUN: begin
                    if (retire) begin
                        div_state <= DIV_IDLE;
                    end else if (div_done) begin
                        div_state <= DIV_DONE;
                    end
                end
                DIV_DONE: if (retire) div_state <= DIV_IDLE;
                default: div_state <= DIV_IDLE;
            endcase
        end
    end

    divider divider_i (
        .clk       (clk),
        .resetn    (resetn),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .quotient  (div_quo),
        .remainder (div_rem),
        .done      (div_done)
    );

    // divides finish when the divider reports done
    assign complete = is_div_op ? (div_done & (div_state != DIV_IDLE)) : 1'b1;

    // one-hot result select
    always_comb begin
        result = '0;
        if (alu_op[exe_pkg::ALU_ADD] | alu_op[exe_pkg::ALU_SUB]) result = adder_sum[31:0];
        if (alu_op[exe_pkg::ALU_SLT])   result = {31'd0, slt_res};
        if (alu_op[exe_pkg::ALU_SLTU])  result = {31'd0, sltu_res};
        if (alu_op[exe_pkg::ALU_AND])   result = src1 & src2;
        if (alu_op[exe_pkg::ALU_NOR])   result = ~(src1 | src2);
        if (alu_op[exe_pkg::ALU_OR])    result = src1 | src2;
        if (alu_op[exe_pkg::ALU_XOR])   result = src1 ^ src2;
        if (alu_op[exe_pkg::ALU_SLL])   result = src1 << shamt;
        if (alu_op[exe_pkg::ALU_SRL])   result = src1 >> shamt;
        if (alu_op[exe_pkg::ALU_SRA])   result = $signed(src1) >>> shamt;
        if (alu_op[exe_pkg::ALU_LUI])   result = src2;
        if (alu_op[exe_pkg::ALU_MUL])   result = product[31:0];
        if (alu_op[exe_pkg::ALU_MULH] | alu_op[exe_pkg::ALU_MULHU]) result = product[63:32];
        if (alu_op[exe_pkg::ALU_DIV] | alu_op[exe_pkg::ALU_DIVU]) result = div_quo;
        if (alu_op[exe_pkg::ALU_MOD] | alu_op[exe_pkg::ALU_MODU]) result = div_rem;
    end

endmodule

//--- logic/divider.sv
module divider (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  logic          is_signed,
    input  exe_pkg::word_t dividend,
    input  exe_pkg::word_t divisor,
    output exe_pkg::word_t quotient,
    output exe_pkg::word_t remainder,
    output logic          done
);

    // control
    logic       busy;
    logic [5:0] count;

    // datapath
    exe_pkg::word_t rem_q;
    exe_pkg::word_t quo_q;
    exe_pkg::word_t dsr_q;
    logic           neg_q;
    logic           neg_r;

    logic           a_neg;
    logic           b_neg;
    exe_pkg::word_t a_mag;
    exe_pkg::word_t b_mag;
    logic [32:0]    trial;

    // magnitudes of the operands
    assign a_neg = is_signed & dividend[31];
    assign b_neg = is_signed & divisor[31];
    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    // shift in next dividend bit and try to subtract
    assign trial = {rem_q, quo_q[31]} - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= 6'd0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= 6'd0;
        end else if (busy) begin
            count <= count + 6'd1;
            // 32nd step finishes
            if (count == 6'd31) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dsr_q <= b_mag;
            // zero divisor keeps the all-ones quotient unsigned
            neg_q <= (a_neg ^ b_neg) & (divisor != '0);
            neg_r <= a_neg;
        end else if (busy) begin
            if (!trial[32]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                // restore
                rem_q <= {rem_q[30:0], quo_q[31]};
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // sign fixup on the way out
    assign quotient  = neg_q ? -quo_q : quo_q;
    assign remainder = neg_r ? -rem_q : rem_q;

endmodule

//--- logic/exe_issue_reg.sv
module exe_issue_reg (
    input  logic               clk,
    input  logic               resetn,
    input  logic               ds2es_valid,
    input  exe_pkg::ds2es_bus_t ds2es_bus,
    input  logic               complete,
    input  logic               ms_allowin,
    output logic               es_allowin,
    output logic               es_valid,
    output exe_pkg::ds2es_bus_t es_bus
);

    logic accept;

    // empty, or current one is about to leave
    assign es_allowin = ~es_valid | (complete & ms_allowin);
    assign accept     = ds2es_valid & es_allowin;

    // stage valid bit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            // leaving with nothing behind drops to empty
            es_valid <= ds2es_valid;
        end
    end

    // bundle register, loaded only on acceptance
    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_bus <= '0;
        end else if (accept) begin
            es_bus <= ds2es_bus;
        end
    end

endmodule

//--- logic/exe_pkg.sv
package exe_pkg;

    // widths fixed by the ISA
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_strb_t;
    typedef logic [4:0]  ld_kind_t;
    typedef logic [18:0] alu_op_t;

    // bit positions in the one-hot alu_op vector
    localparam int ALU_ADD   = 0;
    localparam int ALU_SUB   = 1;
    localparam int ALU_SLT   = 2;
    localparam int ALU_SLTU  = 3;
    localparam int ALU_AND   = 4;
    localparam int ALU_NOR   = 5;
    localparam int ALU_OR    = 6;
    localparam int ALU_XOR   = 7;
    localparam int ALU_SLL   = 8;
    localparam int ALU_SRL   = 9;
    localparam int ALU_SRA   = 10;
    localparam int ALU_LUI   = 11;
    localparam int ALU_MUL   = 12;
    localparam int ALU_MULH  = 13;
    localparam int ALU_MULHU = 14;
    localparam int ALU_DIV   = 15;
    localparam int ALU_MOD   = 16;
    localparam int ALU_DIVU  = 17;
    localparam int ALU_MODU  = 18;

    // decoded instruction handed over by the decode stage
    typedef struct packed {
        alu_op_t   alu_op;
        logic      res_from_mem;
        word_t     src1;
        word_t     src2;
        logic      rf_we;
        reg_addr_t rf_waddr;
        // store data from rd
        word_t     rkd_value;
        logic      st_b;
        logic      st_h;
        logic      st_w;
        word_t     pc;
        ld_kind_t  ld_kind;
    } ds2es_bus_t;

    // forwarding word seen by the memory stage
    typedef struct packed {
        logic      res_from_mem;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     alu_result;
    } es_rf_zip_t;

endpackage

//--- logic/exe_stage.sv
module exe_stage (
    input  logic                clk,
    input  logic                resetn,
    // from decode
    input  logic                ds2es_valid,
    input  exe_pkg::ds2es_bus_t  ds2es_bus,
    output logic                es_allowin,
    // to memory stage
    input  logic                ms_allowin,
    output logic                es2ms_valid,
    output exe_pkg::es_rf_zip_t  es_rf_zip,
    output exe_pkg::word_t       es_pc,
    output exe_pkg::ld_kind_t    es_ld_kind,
    // data SRAM request
    output logic                data_sram_en,
    output exe_pkg::byte_strb_t  data_sram_we,
    output exe_pkg::word_t       data_sram_addr,
    output exe_pkg::word_t       data_sram_wdata
);

    logic                es_valid;
    exe_pkg::ds2es_bus_t es_bus;
    exe_pkg::word_t      alu_result;
    logic                complete;
    logic                retire;

    assign es2ms_valid = es_valid & complete;
    // instruction leaves this edge
    assign retire      = es2ms_valid & ms_allowin;

    assign es_pc      = es_bus.pc;
    assign es_ld_kind = es_bus.ld_kind;

    exe_issue_reg exe_issue_reg_i (
        .clk         (clk),
        .resetn      (resetn),
        .ds2es_valid (ds2es_valid),
        .ds2es_bus   (ds2es_bus),
        .complete    (complete),
        .ms_allowin  (ms_allowin),
        .es_allowin  (es_allowin),
        .es_valid    (es_valid),
        .es_bus      (es_bus)
    );

    alu alu_i (
        .clk      (clk),
        .resetn   (resetn),
        .op_valid (es_valid),
        .retire   (retire),
        .alu_op   (es_bus.alu_op),
        .src1     (es_bus.src1),
        .src2     (es_bus.src2),
        .result   (alu_result),
        .complete (complete)
    );

    store_unit store_unit_i (
        .es_valid        (es_valid),
        .es_bus          (es_bus),
        .alu_result      (alu_result),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .es_rf_zip       (es_rf_zip)
    );

endmodule

//--- logic/store_unit.sv
module store_unit (
    input  logic                es_valid,
    input  exe_pkg::ds2es_bus_t  es_bus,
    input  exe_pkg::word_t       alu_result,
    output logic                data_sram_en,
    output exe_pkg::byte_strb_t  data_sram_we,
    output exe_pkg::word_t       data_sram_addr,
    output exe_pkg::word_t       data_sram_wdata,
    output exe_pkg::es_rf_zip_t  es_rf_zip
);

    exe_pkg::byte_strb_t strb;
    logic [1:0]          addr_lo;

    assign addr_lo = alu_result[1:0];

    // byte lanes from store size and address offset
    always_comb begin
        if (es_bus.st_w) begin
            strb = 4'b1111;
        end else if (es_bus.st_h) begin
            strb = addr_lo[1] ? 4'b1100 : 4'b0011;
        end else if (es_bus.st_b) begin
            strb = 4'b0001 << addr_lo;
        end else begin
            strb = 4'b0000;
        end
    end

    // replicate so every lane sees the data
    always_comb begin
        if (es_bus.st_b) begin
            data_sram_wdata = {4{es_bus.rkd_value[7:0]}};
        end else if (es_bus.st_h) begin
            data_sram_wdata = {2{es_bus.rkd_value[15:0]}};
        end else begin
            data_sram_wdata = es_bus.rkd_value;
        end
    end

    assign data_sram_en   = es_valid & (es_bus.res_from_mem | (|strb));
    assign data_sram_we   = strb & {4{es_valid}};
    assign data_sram_addr = alu_result;

    // flags dropped when the stage is empty
    assign es_rf_zip.res_from_mem = es_bus.res_from_mem & es_valid;
    assign es_rf_zip.rf_we        = es_bus.rf_we & es_valid;
    assign es_rf_zip.rf_waddr     = es_bus.rf_waddr;
    assign es_rf_zip.alu_result   = alu_result;

endmodule

//--- verification/exe_stage_checker.sv
module exe_stage_checker (
    input logic                clk,
    input logic                resetn,
    input logic                ds2es_valid,
    input logic                es_allowin,
    input logic                ms_allowin,
    input logic                es2ms_valid,
    input exe_pkg::es_rf_zip_t es_rf_zip,
    input exe_pkg::word_t      es_pc,
    input exe_pkg::ld_kind_t   es_ld_kind,
    input logic                data_sram_en,
    input exe_pkg::byte_strb_t data_sram_we,
    input exe_pkg::word_t      data_sram_addr,
    input exe_pkg::word_t      data_sram_wdata
);

    int   fail_count;
    logic held;

    // result ready but memory stage not taking it
    assign held = es2ms_valid & ~ms_allowin;

    // quiet in reset and one cycle after
    reset_quiet: assert property (@(posedge clk)
        $past(!resetn) |-> !es2ms_valid && data_sram_we == 4'b0000)
    else begin
        $error("es2ms_valid or data_sram_we active around reset");
        fail_count++;
    end

    hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        held |=> es2ms_valid && $stable(es_rf_zip) && $stable(es_pc)
            && $stable(es_ld_kind) && $stable(data_sram_en) && $stable(data_sram_we)
            && $stable(data_sram_addr) && $stable(data_sram_wdata))
    else begin
        $error("outputs changed while the stage was held");
        fail_count++;
    end

    hold_blocks_input: assert property (@(posedge clk) disable iff (!resetn)
        held |-> !es_allowin)
    else begin
        $error("es_allowin high while the stage was held");
        fail_count++;
    end

    // divides take 33 cycles after es_valid
    bounded_latency: assert property (@(posedge clk) disable iff (!resetn)
        ds2es_valid && es_allowin |-> ##[1:34] es2ms_valid)
    else begin
        $error("es2ms_valid did not rise within 34 cycles of acceptance");
        fail_count++;
    end

endmodule

bind exe_stage exe_stage_checker exe_stage_checker_i (
    .clk             (clk),
    .resetn          (resetn),
    .ds2es_valid     (ds2es_valid),
    .es_allowin      (es_allowin),
    .ms_allowin      (ms_allowin),
    .es2ms_valid     (es2ms_valid),
    .es_rf_zip       (es_rf_zip),
    .es_pc           (es_pc),
    .es_ld_kind      (es_ld_kind),
    .data_sram_en    (data_sram_en),
    .data_sram_we    (data_sram_we),
    .data_sram_addr  (data_sram_addr),
    .data_sram_wdata (data_sram_wdata)
);

//--- verification/exe_stage_monitor.sv
module exe_stage_monitor (
    input  logic                clk,
    input  logic                resetn,
    input  logic                ds2es_valid,
    input  exe_pkg::ds2es_bus_t ds2es_bus,
    input  logic                es_allowin,
    input  logic                ms_allowin,
    input  logic                es2ms_valid,
    input  exe_pkg::es_rf_zip_t es_rf_zip,
    input  exe_pkg::word_t      es_pc,
    input  exe_pkg::ld_kind_t   es_ld_kind,
    input  logic                data_sram_en,
    input  exe_pkg::byte_strb_t data_sram_we,
    input  exe_pkg::word_t      data_sram_addr,
    input  exe_pkg::word_t      data_sram_wdata,
    output int                  pending,
    output int                  xfer_count,
    output int                  err_count
);

    // what the memory stage should see when an instruction leaves
    typedef struct packed {
        exe_pkg::es_rf_zip_t zip;
        exe_pkg::word_t      pc;
        exe_pkg::ld_kind_t   ld_kind;
        logic                sram_en;
        exe_pkg::byte_strb_t sram_we;
        exe_pkg::word_t      sram_addr;
        exe_pkg::word_t      sram_wdata;
    } xfer_t;

    xfer_t exp_q[$];
    logic  in_reset_q;

    function automatic exe_pkg::word_t divide_model(input exe_pkg::word_t a,
                                                    input exe_pkg::word_t b,
                                                    input logic is_signed,
                                                    input logic want_rem);
        exe_pkg::word_t q;
        exe_pkg::word_t r;
        if (b == 32'h0) begin
            q = 32'hffff_ffff;
            r = a;
        end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            // overflow case
            q = 32'h8000_0000;
            r = 32'h0;
        end else if (is_signed) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return want_rem ? r : q;
    endfunction

    function automatic exe_pkg::word_t model_result(input exe_pkg::alu_op_t op,
                                                    input exe_pkg::word_t a,
                                                    input exe_pkg::word_t b);
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        int                 idx;
        idx   = 0;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'd0, a} * {32'd0, b};
        for (int i = 0; i < 19; i++) begin
            if (op[i]) begin
                idx = i;
            end
        end
        case (idx)
            exe_pkg::ALU_ADD:   return a + b;
            exe_pkg::ALU_SUB:   return a - b;
            exe_pkg::ALU_SLT:   return {31'd0, $signed(a) < $signed(b)};
            exe_pkg::ALU_SLTU:  return {31'd0, a < b};
            exe_pkg::ALU_AND:   return a & b;
            exe_pkg::ALU_NOR:   return ~(a | b);
            exe_pkg::ALU_OR:    return a | b;
            exe_pkg::ALU_XOR:   return a ^ b;
            exe_pkg::ALU_SLL:   return a << b[4:0];
            exe_pkg::ALU_SRL:   return a >> b[4:0];
            exe_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
            exe_pkg::ALU_LUI:   return b;
            exe_pkg::ALU_MUL:   return uprod[31:0];
            exe_pkg::ALU_MULH:  return sprod[63:32];
            exe_pkg::ALU_MULHU: return uprod[63:32];
            exe_pkg::ALU_DIV:   return divide_model(a, b, 1'b1, 1'b0);
            exe_pkg::ALU_MOD:   return divide_model(a, b, 1'b1, 1'b1);
            exe_pkg::ALU_DIVU:  return divide_model(a, b, 1'b0, 1'b0);
            default:            return divide_model(a, b, 1'b0, 1'b1);
        endcase
    endfunction

    function automatic xfer_t expect_transfer(input exe_pkg::ds2es_bus_t b);
        xfer_t          x;
        exe_pkg::word_t res;
        res                = model_result(b.alu_op, b.src1, b.src2);
        x.zip.res_from_mem = b.res_from_mem;
        x.zip.rf_we        = b.rf_we;
        x.zip.rf_waddr     = b.rf_waddr;
        x.zip.alu_result   = res;
        x.pc               = b.pc;
        x.ld_kind          = b.ld_kind;
        x.sram_addr        = res;
        x.sram_wdata       = b.rkd_value;
        x.sram_we          = 4'b0000;
        if (b.st_w) begin
            x.sram_we = 4'b1111;
        end else if (b.st_h) begin
            x.sram_we    = res[1] ? 4'b1100 : 4'b0011;
            x.sram_wdata = {2{b.rkd_value[15:0]}};
        end else if (b.st_b) begin
            x.sram_we    = 4'b0001 << res[1:0];
            x.sram_wdata = {4{b.rkd_value[7:0]}};
        end
        x.sram_en = b.res_from_mem | (x.sram_we != 4'b0000);
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
            err_count++;
        end
    endtask

    always @(posedge clk) begin
        xfer_t exp;
        logic  exp_allowin;
        // state must be cleared once reset has been seen
        if (in_reset_q) begin
            compare_value("es2ms_valid", 32'd0, {31'd0, es2ms_valid});
            compare_value("data_sram_en", 32'd0, {31'd0, data_sram_en});
            compare_value("data_sram_we", 32'd0, {28'd0, data_sram_we});
        end
        if (resetn) begin
            // stage empty or its instruction leaving
            exp_allowin = (exp_q.size() == 0) || (es2ms_valid && ms_allowin);
            compare_value("es_allowin", {31'd0, exp_allowin}, {31'd0, es_allowin});
            if (es2ms_valid && ms_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: an instruction left the stage with none outstanding at %0t",
                             $time);
                    err_count++;
                end else begin
                    exp = exp_q.pop_front();
                    compare_value("es_rf_zip.alu_result", exp.zip.alu_result,
                                  es_rf_zip.alu_result);
                    compare_value("es_rf_zip.res_from_mem", {31'd0, exp.zip.res_from_mem},
                                  {31'd0, es_rf_zip.res_from_mem});
                    compare_value("es_rf_zip.rf_we", {31'd0, exp.zip.rf_we},
                                  {31'd0, es_rf_zip.rf_we});
                    compare_value("es_rf_zip.rf_waddr", {27'd0, exp.zip.rf_waddr},
                                  {27'd0, es_rf_zip.rf_waddr});
                    compare_value("es_pc", exp.pc, es_pc);
                    compare_value("es_ld_kind", {27'd0, exp.ld_kind}, {27'd0, es_ld_kind});
                    compare_value("data_sram_en", {31'd0, exp.sram_en}, {31'd0, data_sram_en});
                    compare_value("data_sram_we", {28'd0, exp.sram_we}, {28'd0, data_sram_we});
                    compare_value("data_sram_addr", exp.sram_addr, data_sram_addr);
                    compare_value("data_sram_wdata", exp.sram_wdata, data_sram_wdata);
                    xfer_count++;
                end
            end
            if (ds2es_valid && es_allowin) begin
                exp_q.push_back(expect_transfer(ds2es_bus));
            end
        end
        pending = exp_q.size();
        in_reset_q <= !resetn;
    end

endmodule

//--- verification/exe_stage_tb.sv
module exe_stage_tb;

    localparam int NUM_TESTS        = 5;
    localparam int PER_TEST         = 80;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 16;

    logic                clk;
    logic                resetn;
    logic                ds2es_valid;
    exe_pkg::ds2es_bus_t ds2es_bus;
    logic                es_allowin;
    logic                ms_allowin;
    logic                es2ms_valid;
    exe_pkg::es_rf_zip_t es_rf_zip;
    exe_pkg::word_t      es_pc;
    exe_pkg::ld_kind_t   es_ld_kind;
    logic                data_sram_en;
    exe_pkg::byte_strb_t data_sram_we;
    exe_pkg::word_t      data_sram_addr;
    exe_pkg::word_t      data_sram_wdata;

    int                  pending;
    int                  xfer_count;
    int                  err_count;
    logic [31:0]         lcg_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exe_stage exe_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .ds2es_valid     (ds2es_valid),
        .ds2es_bus       (ds2es_bus),
        .es_allowin      (es_allowin),
        .ms_allowin      (ms_allowin),
        .es2ms_valid     (es2ms_valid),
        .es_rf_zip       (es_rf_zip),
        .es_pc           (es_pc),
        .es_ld_kind      (es_ld_kind),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    exe_stage_monitor exe_stage_monitor_i (
        .clk             (clk),
        .resetn          (resetn),
        .ds2es_valid     (ds2es_valid),
        .ds2es_bus       (ds2es_bus),
        .es_allowin      (es_allowin),
        .ms_allowin      (ms_allowin),
        .es2ms_valid     (es2ms_valid),
        .es_rf_zip       (es_rf_zip),
        .es_pc           (es_pc),
        .es_ld_kind      (es_ld_kind),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .pending         (pending),
        .xfer_count      (xfer_count),
        .err_count       (err_count)
    );

    // lcg step with the upper half rotated down for better low bits
    function automatic exe_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // op mix per test
    function automatic int pick_op(input int test);
        exe_pkg::word_t r;
        r = next_rand();
        case (test)
            0:       return r % 12;
            1:       return (r[7:0] < 64) ? (r >> 8) % 12 : 12 + (r >> 8) % 3;
            2:       return (r[7:0] < 64) ? (r >> 8) % 15 : 15 + (r >> 8) % 4;
            3:       return (r[7:0] < 192) ? exe_pkg::ALU_ADD : (r >> 8) % 19;
            default: return r % 19;
        endcase
    endfunction

    // edge values one time in eight
    function automatic exe_pkg::word_t pick_operand();
        exe_pkg::word_t r;
        r = next_rand();
        if (r % 8 != 0) begin
            return next_rand();
        end
        case ((r >> 8) % 6)
            0:       return 32'h0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return (r >> 16) % 4 + 1;
            4:       return -((r >> 16) % 4 + 1);
            default: return 32'h0;
        endcase
    endfunction

    function automatic exe_pkg::ds2es_bus_t make_bundle(input int test);
        exe_pkg::ds2es_bus_t b;
        exe_pkg::word_t      r;
        int                  kind;
        b        = '0;
        b.alu_op = 19'd1 << pick_op(test);
        b.src1   = pick_operand();
        b.src2   = pick_operand();
        if (test == 2 && next_rand() % 8 == 0) begin
            b.src1 = 32'h8000_0000;
            b.src2 = 32'hffff_ffff;
        end
        r    = next_rand();
        kind = r % 4;
        // load, store, or plain register write
        if (kind == 0) begin
            b.res_from_mem = 1'b1;
            b.rf_we        = 1'b1;
        end else if (kind == 1 || (test == 3 && kind == 2)) begin
            case ((r >> 8) % 3)
                0:       b.st_b = 1'b1;
                1:       b.st_h = 1'b1;
                default: b.st_w = 1'b1;
            endcase
        end else begin
            b.rf_we = 1'b1;
        end
        b.rf_waddr  = r[20:16];
        b.ld_kind   = r[28:24];
        b.rkd_value = next_rand();
        b.pc        = next_rand() & 32'hffff_fffc;
        return b;
    endfunction

    function automatic string test_name(input int test);
        case (test)
            0:       return "simple ALU";
            1:       return "multiply";
            2:       return "divide and modulo";
            3:       return "loads and stores";
            default: return "full mix";
        endcase
    endfunction

    task automatic run_test(input int test);
        int sent;
        sent = 0;
        while (sent < PER_TEST) begin
            @(posedge clk);
            if (ds2es_valid && es_allowin) begin
                sent++;
            end
            // decode holds its bundle until the stage takes it
            if (!ds2es_valid || es_allowin) begin
                if (sent < PER_TEST && next_rand() % 4 != 0) begin
                    ds2es_bus   <= make_bundle(test);
                    ds2es_valid <= 1'b1;
                end else begin
                    ds2es_valid <= 1'b0;
                end
            end
            ms_allowin <= (next_rand() % 3) != 0;
        end
    endtask

    task automatic drain_stage();
        @(negedge clk);
        while (pending != 0) begin
            @(posedge clk);
            ms_allowin <= (next_rand() % 3) != 0;
            @(negedge clk);
        end
    endtask

    // watchdog sized from the test length
    initial begin
        #((NUM_TESTS * PER_TEST * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD);
        $display("ERROR: timeout, the stage stopped delivering instructions");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int prev_xfer;
        int prev_err;
        int assert_fails;
        int count_errors;
        clk         = 1'b0;
        resetn      = 1'b0;
        ds2es_valid = 1'b0;
        ds2es_bus   = '0;
        ms_allowin  = 1'b0;
        lcg_state   = 32'd88;
        count_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            prev_xfer = xfer_count;
            prev_err  = err_count + exe_stage_i.exe_stage_checker_i.fail_count;
            run_test(t);
            drain_stage();
            $display("test %0d %s: %0d transfers, %0d errors", t, test_name(t),
                     xfer_count - prev_xfer,
                     err_count + exe_stage_i.exe_stage_checker_i.fail_count - prev_err);
        end
        assert_fails = exe_stage_i.exe_stage_checker_i.fail_count;
        if (xfer_count != NUM_TESTS * PER_TEST) begin
            $display("ERROR: %0d instructions were accepted but %0d left the stage",
                     NUM_TESTS * PER_TEST, xfer_count);
            count_errors++;
        end
        $display("totals: %0d transfers, %0d mismatches, %0d assertion failures",
                 xfer_count, err_count + count_errors, assert_fails);
        if (err_count == 0 && assert_fails == 0 && count_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
